// File: source/packet_buffer_pkg.sv
// packet buffer shared definitions: widths, depths, register map, control bits and FSM codes
package packet_buffer_pkg;

    // packet and SRAM geometry
    localparam int PACKET_W     = 32;
    localparam int PACKET_LINES = 64;
    localparam int ADDR_W       = 6;

    // pointers and counters need one extra bit to hold a full count of 64
    localparam int CNT_W = 7;

    // output FIFO
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // register bus
    localparam int REG_ADDR_W = 3;
    localparam int REG_W      = 32;

    localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 3'd0;
    localparam logic [REG_ADDR_W-1:0] REG_STATUS = 3'd1;
    localparam logic [REG_ADDR_W-1:0] REG_WCOUNT = 3'd2;
    localparam logic [REG_ADDR_W-1:0] REG_RCOUNT = 3'd3;
    localparam logic [REG_ADDR_W-1:0] REG_DROPS  = 3'd4;

    // bit positions inside a write to REG_CTRL
    localparam int CTRL_START  = 0;
    localparam int CTRL_DONE   = 1;
    localparam int CTRL_REPLAY = 2;
    localparam int CTRL_CLEAR  = 3;

    // controller FSM codes, read back in REG_STATUS bits 1:0
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_STREAM = 2'd1;
    localparam logic [1:0] ST_STALL  = 2'd2;

endpackage

// File: source/packet_sram.sv
// packet SRAM: single-port behavioral array with synchronous write and registered read
module packet_sram (
    input  logic                                  clk,
    input  logic                                  en,
    input  logic                                  we,
    input  logic [packet_buffer_pkg::ADDR_W-1:0]   addr,
    input  logic [packet_buffer_pkg::PACKET_W-1:0] wdata,
    output logic [packet_buffer_pkg::PACKET_W-1:0] rdata
);
    import packet_buffer_pkg::*;

    logic [PACKET_W-1:0] mem [PACKET_LINES];

    // one access per cycle, a write leaves rdata untouched
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: source/packet_fifo.sv
// output FIFO: circular buffer with a nearly-full flag for the reader and a consumer pop
module packet_fifo (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  clear,
    input  logic                                  push,
    input  logic [packet_buffer_pkg::PACKET_W-1:0] push_data,
    input  logic                                  pop,
    output logic [packet_buffer_pkg::PACKET_W-1:0] head_data,
    output logic                                  empty,
    output logic                                  nearly_full
);
    import packet_buffer_pkg::*;

    logic [PACKET_W-1:0]   entries [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  do_pop;

    // a pop on an empty FIFO is simply ignored
    assign do_pop = pop && !empty;

    assign empty       = (count == '0);
    assign nearly_full = (count >= FIFO_CNT_W'(FIFO_DEPTH - 1));
    assign head_data   = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// File: source/buffer_regs.sv
// buffer register block: control pulses, status and count readback, drop counter
module buffer_regs (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    reg_wen,
    input  logic                                    reg_ren,
    input  logic [packet_buffer_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [packet_buffer_pkg::REG_W-1:0]      reg_wdata,
    input  logic [1:0]                              state,
    input  logic [packet_buffer_pkg::CNT_W-1:0]      write_count,
    input  logic [packet_buffer_pkg::CNT_W-1:0]      read_count,
    input  logic                                    drop_strobe,
    output logic [packet_buffer_pkg::REG_W-1:0]      reg_rdata,
    output logic                                    reg_rvalid,
    output logic                                    start_pulse,
    output logic                                    done_pulse,
    output logic                                    replay_pulse,
    output logic                                    clear_pulse
);
    import packet_buffer_pkg::*;

    logic             ctrl_write;
    logic [REG_W-1:0] drop_count;
    logic [REG_W-1:0] read_mux;

    assign ctrl_write = reg_wen && (reg_addr == REG_CTRL);

    // each control bit turns into a one-cycle pulse the cycle after the write
    always_ff @(posedge clk) begin
        if (reset) begin
            start_pulse  <= 1'b0;
            done_pulse   <= 1'b0;
            replay_pulse <= 1'b0;
            clear_pulse  <= 1'b0;
        end else begin
            start_pulse  <= ctrl_write && reg_wdata[CTRL_START];
            done_pulse   <= ctrl_write && reg_wdata[CTRL_DONE];
            replay_pulse <= ctrl_write && reg_wdata[CTRL_REPLAY];
            clear_pulse  <= ctrl_write && reg_wdata[CTRL_CLEAR];
        end
    end

    // zeroed on the same edge where the controller drops its counts
    always_ff @(posedge clk) begin
        if (reset || clear_pulse) begin
            drop_count <= '0;
        end else if (drop_strobe) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    always_comb begin
        case (reg_addr)
            REG_STATUS: read_mux = REG_W'(state);
            REG_WCOUNT: read_mux = REG_W'(write_count);
            REG_RCOUNT: read_mux = REG_W'(read_count);
            REG_DROPS:  read_mux = drop_count;
            default:    read_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_ren;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_ren) begin
            reg_rdata <= read_mux;
        end
    end

endmodule

// File: source/packet_store_ctrl.sv
// packet store controller: arbitrates the dp and edge writers against SRAM reads into the FIFO
module packet_store_ctrl (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  start_pulse,
    input  logic                                  done_pulse,
    input  logic                                  replay_pulse,
    input  logic                                  clear_pulse,
    input  logic                                  dp_valid,
    input  logic [packet_buffer_pkg::PACKET_W-1:0] dp_packet,
    input  logic                                  edge_valid,
    input  logic [packet_buffer_pkg::PACKET_W-1:0] edge_packet,
    input  logic                                  fifo_nearly_full,
    output logic                                  mem_en,
    output logic                                  mem_we,
    output logic [packet_buffer_pkg::ADDR_W-1:0]   mem_addr,
    output logic [packet_buffer_pkg::PACKET_W-1:0] mem_wdata,
    output logic                                  fifo_push,
    output logic                                  drop_strobe,
    output logic [1:0]                            state,
    output logic [packet_buffer_pkg::CNT_W-1:0]    write_count,
    output logic [packet_buffer_pkg::CNT_W-1:0]    read_count
);
    import packet_buffer_pkg::*;

    logic [1:0] state_next;
    logic       streaming;
    logic       any_valid;
    logic       buf_full;
    logic       wr_accept;
    logic       rd_issue;
    logic       rd_inflight;

    assign streaming = (state == ST_STREAM);
    assign any_valid = dp_valid || edge_valid;
    assign buf_full  = (write_count == CNT_W'(PACKET_LINES));

    // a write that lands on a clear would be wiped at the same edge, so it counts as a drop
    assign wr_accept = streaming && any_valid && !buf_full && !clear_pulse;

    // reads only fill idle SRAM cycles and never race a pointer reset
    assign rd_issue = streaming && !any_valid && (read_count < write_count)
                      && !fifo_nearly_full && !replay_pulse && !clear_pulse;

    // dp always wins, so a simultaneous edge packet is lost
    assign drop_strobe = (dp_valid && edge_valid) || (any_valid && !wr_accept);

    assign mem_en    = wr_accept || rd_issue;
    assign mem_we    = wr_accept;
    assign mem_wdata = dp_valid ? dp_packet : edge_packet;

    always_comb begin
        if (wr_accept) begin
            mem_addr = write_count[ADDR_W-1:0];
        end else begin
            mem_addr = read_count[ADDR_W-1:0];
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start_pulse) begin
                    state_next = ST_STREAM;
                end
            end
            ST_STREAM: begin
                if (done_pulse) begin
                    state_next = ST_STALL;
                end
            end
            ST_STALL: begin
                state_next = ST_STALL;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
        if (replay_pulse) begin
            state_next = ST_STREAM;
        end
        // clear outranks everything else
        if (clear_pulse) begin
            state_next = ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear_pulse) begin
            write_count <= '0;
            read_count  <= '0;
        end else begin
            if (wr_accept) begin
                write_count <= write_count + 1'b1;
            end
            // replay only rewinds the reader so the stored packets stream again
            if (replay_pulse) begin
                read_count <= '0;
            end else if (rd_issue) begin
                read_count <= read_count + 1'b1;
            end
        end
    end

    // SRAM data shows up one cycle after the read, together with this push
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_inflight <= 1'b0;
        end else begin
            rd_inflight <= rd_issue;
        end
    end

    assign fifo_push = rd_inflight;

endmodule

// File: source/packet_buffer_top.sv
// packet buffer top: controller, packet SRAM, output FIFO and register block
module packet_buffer_top (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    dp_valid,
    input  logic [packet_buffer_pkg::PACKET_W-1:0]   dp_packet,
    input  logic                                    edge_valid,
    input  logic [packet_buffer_pkg::PACKET_W-1:0]   edge_packet,
    input  logic                                    reg_wen,
    input  logic                                    reg_ren,
    input  logic [packet_buffer_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [packet_buffer_pkg::REG_W-1:0]      reg_wdata,
    input  logic                                    out_pop,
    output logic [packet_buffer_pkg::PACKET_W-1:0]   out_packet,
    output logic                                    out_empty,
    output logic [packet_buffer_pkg::REG_W-1:0]      reg_rdata,
    output logic                                    reg_rvalid
);
    import packet_buffer_pkg::*;

    logic                start_pulse;
    logic                done_pulse;
    logic                replay_pulse;
    logic                clear_pulse;
    logic [1:0]          state;
    logic [CNT_W-1:0]    write_count;
    logic [CNT_W-1:0]    read_count;
    logic                drop_strobe;
    logic                mem_en;
    logic                mem_we;
    logic [ADDR_W-1:0]   mem_addr;
    logic [PACKET_W-1:0] mem_wdata;
    logic [PACKET_W-1:0] mem_rdata;
    logic                fifo_push;
    logic                fifo_nearly_full;

    packet_store_ctrl u_ctrl (
        .clk              (clk),
        .reset            (reset),
        .start_pulse      (start_pulse),
        .done_pulse       (done_pulse),
        .replay_pulse     (replay_pulse),
        .clear_pulse      (clear_pulse),
        .dp_valid         (dp_valid),
        .dp_packet        (dp_packet),
        .edge_valid       (edge_valid),
        .edge_packet      (edge_packet),
        .fifo_nearly_full (fifo_nearly_full),
        .mem_en           (mem_en),
        .mem_we           (mem_we),
        .mem_addr         (mem_addr),
        .mem_wdata        (mem_wdata),
        .fifo_push        (fifo_push),
        .drop_strobe      (drop_strobe),
        .state            (state),
        .write_count      (write_count),
        .read_count       (read_count)
    );

    packet_sram u_sram (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    // the clear pulse also flushes whatever is waiting in the FIFO
    packet_fifo u_fifo (
        .clk         (clk),
        .reset       (reset),
        .clear       (clear_pulse),
        .push        (fifo_push),
        .push_data   (mem_rdata),
        .pop         (out_pop),
        .head_data   (out_packet),
        .empty       (out_empty),
        .nearly_full (fifo_nearly_full)
    );

    buffer_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .reg_wen      (reg_wen),
        .reg_ren      (reg_ren),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .state        (state),
        .write_count  (write_count),
        .read_count   (read_count),
        .drop_strobe  (drop_strobe),
        .reg_rdata    (reg_rdata),
        .reg_rvalid   (reg_rvalid),
        .start_pulse  (start_pulse),
        .done_pulse   (done_pulse),
        .replay_pulse (replay_pulse),
        .clear_pulse  (clear_pulse)
    );

endmodule

// File: bench/packet_buffer_tb.sv
// packet buffer testbench: directed tests against a reference queue and line model
module packet_buffer_tb;
    import packet_buffer_pkg::*;

    // well under 1000 cycles of tests in total, the limit leaves a wide margin
    localparam int CYCLE_LIMIT = 4000;
    localparam int POP_WAIT    = 40;

    logic                  clk;
    logic                  reset;
    logic                  dp_valid;
    logic [PACKET_W-1:0]   dp_packet;
    logic                  edge_valid;
    logic [PACKET_W-1:0]   edge_packet;
    logic                  reg_wen;
    logic                  reg_ren;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [REG_W-1:0]      reg_wdata;
    logic                  out_pop;
    logic [PACKET_W-1:0]   out_packet;
    logic                  out_empty;
    logic [REG_W-1:0]      reg_rdata;
    logic                  reg_rvalid;

    // reference model of what the buffer holds and what must come out
    logic [PACKET_W-1:0] expect_q [$];
    logic [PACKET_W-1:0] line_model [PACKET_LINES];
    int                  model_wcount;
    int                  model_drops;
    logic [1:0]          model_state;

    integer seed;
    int     error_count;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    int     cycle_count;

    packet_buffer_top uut (
        .clk         (clk),
        .reset       (reset),
        .dp_valid    (dp_valid),
        .dp_packet   (dp_packet),
        .edge_valid  (edge_valid),
        .edge_packet (edge_packet),
        .reg_wen     (reg_wen),
        .reg_ren     (reg_ren),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .out_pop     (out_pop),
        .out_packet  (out_packet),
        .out_empty   (out_empty),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic void check_value(input string name, input logic [31:0] got,
                                        input logic [31:0] want);
        assert (got === want) else begin
            $display("[ERROR] %s got %h expected %h", name, got, want);
            error_count++;
        end
    endfunction

    function automatic logic [PACKET_W-1:0] next_packet();
        next_packet = $random(seed);
    endfunction

    task automatic write_ctrl(input int bit_pos);
        int i;
        @(posedge clk);
        reg_wen   <= 1'b1;
        reg_addr  <= REG_CTRL;
        reg_wdata <= REG_W'(1) << bit_pos;
        @(posedge clk);
        reg_wen   <= 1'b0;
        reg_wdata <= '0;
        // the pulse is registered, the controller acts one edge later
        @(posedge clk);
        case (bit_pos)
            CTRL_START: begin
                if (model_state == ST_IDLE) model_state = ST_STREAM;
            end
            CTRL_DONE: begin
                if (model_state == ST_STREAM) model_state = ST_STALL;
            end
            CTRL_REPLAY: begin
                // replay is only issued with the output drained, so every line streams again
                model_state = ST_STREAM;
                expect_q.delete();
                for (i = 0; i < model_wcount; i++) expect_q.push_back(line_model[i]);
            end
            CTRL_CLEAR: begin
                model_state  = ST_IDLE;
                model_wcount = 0;
                model_drops  = 0;
                expect_q.delete();
            end
            default: begin
            end
        endcase
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [REG_W-1:0] data);
        @(posedge clk);
        reg_ren  <= 1'b1;
        reg_addr <= addr;
        @(posedge clk);
        reg_ren <= 1'b0;
        // read data is valid for exactly the one cycle after the request
        @(negedge clk);
        assert (reg_rvalid) else begin
            $display("register read at address %0d got no reg_rvalid one cycle later", addr);
            error_count++;
        end
        data = reg_rdata;
        @(negedge clk);
        assert (!reg_rvalid) else begin
            $display("reg_rvalid stayed high for more than one cycle after a read");
            error_count++;
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] addr,
                             input logic [REG_W-1:0] want);
        logic [REG_W-1:0] got;
        read_reg(addr, got);
        check_value(name, got, want);
    endtask

    task automatic send_packets(input logic dp_on, input logic edge_on,
                                input logic [PACKET_W-1:0] dp_pkt,
                                input logic [PACKET_W-1:0] edge_pkt);
        @(posedge clk);
        dp_valid    <= dp_on;
        edge_valid  <= edge_on;
        dp_packet   <= dp_pkt;
        edge_packet <= edge_pkt;
        @(posedge clk);
        dp_valid   <= 1'b0;
        edge_valid <= 1'b0;
        // dp wins, edge is lost when both arrive, nothing is taken outside stream or when full
        if (model_state == ST_STREAM && model_wcount < PACKET_LINES && (dp_on || edge_on)) begin
            line_model[model_wcount] = dp_on ? dp_pkt : edge_pkt;
            expect_q.push_back(line_model[model_wcount]);
            model_wcount++;
            if (dp_on && edge_on) model_drops++;
        end else if (dp_on || edge_on) begin
            model_drops++;
        end
    endtask

    task automatic pop_expect();
        logic [PACKET_W-1:0] want;
        int                  waited;
        want   = expect_q.pop_front();
        waited = 0;
        @(negedge clk);
        while (out_empty && waited < POP_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (!out_empty) else begin
            $display("expected packet %h never reached the output", want);
            error_count++;
        end
        if (!out_empty) begin
            check_value("out_packet", out_packet, want);
            @(posedge clk);
            out_pop <= 1'b1;
            @(posedge clk);
            out_pop <= 1'b0;
        end
    endtask

    task automatic drain_output();
        while (expect_q.size() > 0) pop_expect();
    endtask

    task automatic begin_test();
        test_errors = error_count;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", tests_run, name,
                     error_count - test_errors);
        end
    endtask

    task automatic check_reset_state();
        begin_test();
        @(negedge clk);
        check_value("out_empty", 32'(out_empty), 32'd1);
        check_reg("REG_STATUS", REG_STATUS, REG_W'(ST_IDLE));
        check_reg("REG_WCOUNT", REG_WCOUNT, '0);
        check_reg("REG_RCOUNT", REG_RCOUNT, '0);
        check_reg("REG_DROPS", REG_DROPS, '0);
        send_packets(1'b1, 1'b0, next_packet(), '0);
        check_reg("REG_DROPS", REG_DROPS, REG_W'(model_drops));
        end_test("reset state");
    endtask

    task automatic stream_in_order();
        int i;
        begin_test();
        write_ctrl(CTRL_CLEAR);
        write_ctrl(CTRL_START);
        for (i = 0; i < 10; i++) begin
            send_packets(i % 2 == 0, i % 2 == 1, next_packet(), next_packet());
        end
        drain_output();
        check_reg("REG_WCOUNT", REG_WCOUNT, REG_W'(model_wcount));
        check_reg("REG_RCOUNT", REG_RCOUNT, REG_W'(model_wcount));
        end_test("ordered streaming");
    endtask

    task automatic apply_backpressure();
        logic [REG_W-1:0] got;
        int               i;
        begin_test();
        write_ctrl(CTRL_CLEAR);
        write_ctrl(CTRL_START);
        for (i = 0; i < 30; i++) send_packets(1'b1, 1'b0, next_packet(), '0);
        repeat (20) @(posedge clk);
        read_reg(REG_RCOUNT, got);
        assert (got <= REG_W'(FIFO_DEPTH)) else begin
            $display("[ERROR] REG_RCOUNT got %h expected at most %h", got, FIFO_DEPTH);
            error_count++;
        end
        drain_output();
        check_reg("REG_RCOUNT", REG_RCOUNT, REG_W'(30));
        end_test("back-pressure");
    endtask

    task automatic drop_overflow();
        begin_test();
        write_ctrl(CTRL_CLEAR);
        write_ctrl(CTRL_START);
        send_packets(1'b1, 1'b1, next_packet(), next_packet());
        check_reg("REG_DROPS", REG_DROPS, REG_W'(model_drops));
        check_reg("REG_WCOUNT", REG_WCOUNT, REG_W'(1));
        while (model_wcount < PACKET_LINES) send_packets(1'b1, 1'b0, next_packet(), '0);
        repeat (3) send_packets(1'b1, 1'b0, next_packet(), '0);
        check_reg("REG_DROPS", REG_DROPS, REG_W'(4));
        check_reg("REG_WCOUNT", REG_WCOUNT, REG_W'(PACKET_LINES));
        drain_output();
        end_test("drops");
    endtask

    task automatic done_and_replay();
        int i;
        begin_test();
        write_ctrl(CTRL_CLEAR);
        write_ctrl(CTRL_START);
        // more packets than the FIFO holds, so some are still unread when done lands
        for (i = 0; i < 10; i++) send_packets(1'b1, 1'b0, next_packet(), '0);
        write_ctrl(CTRL_DONE);
        check_reg("REG_STATUS", REG_STATUS, REG_W'(ST_STALL));
        @(negedge clk);
        while (!out_empty && expect_q.size() > 0) begin
            pop_expect();
            @(negedge clk);
        end
        assert (expect_q.size() > 0) else begin
            $display("every packet streamed out although reads were still pending at done");
            error_count++;
        end
        // the buffer still has room, so only the stall state can turn these away
        send_packets(1'b1, 1'b0, next_packet(), '0);
        send_packets(1'b0, 1'b1, '0, next_packet());
        check_reg("REG_DROPS", REG_DROPS, REG_W'(model_drops));
        check_reg("REG_WCOUNT", REG_WCOUNT, REG_W'(model_wcount));
        repeat (10) begin
            @(negedge clk);
            check_value("out_empty", 32'(out_empty), 32'd1);
        end
        write_ctrl(CTRL_REPLAY);
        drain_output();
        check_reg("REG_RCOUNT", REG_RCOUNT, REG_W'(model_wcount));
        check_reg("REG_STATUS", REG_STATUS, REG_W'(ST_STREAM));
        end_test("done and replay");
    endtask

    task automatic clear_buffer();
        begin_test();
        // refill the FIFO first so the clear has something to flush
        write_ctrl(CTRL_REPLAY);
        repeat (20) @(posedge clk);
        @(negedge clk);
        assert (!out_empty) else begin
            $display("output stayed empty after a replay of the stored packets");
            error_count++;
        end
        write_ctrl(CTRL_CLEAR);
        @(negedge clk);
        check_value("out_empty", 32'(out_empty), 32'd1);
        // a pop on the empty FIFO leaves it empty
        @(posedge clk);
        out_pop <= 1'b1;
        @(posedge clk);
        out_pop <= 1'b0;
        @(negedge clk);
        check_value("out_empty", 32'(out_empty), 32'd1);
        check_reg("REG_WCOUNT", REG_WCOUNT, '0);
        check_reg("REG_RCOUNT", REG_RCOUNT, '0);
        check_reg("REG_DROPS", REG_DROPS, '0);
        check_reg("REG_STATUS", REG_STATUS, REG_W'(ST_IDLE));
        end_test("clear");
    endtask

    initial begin
        seed         = 32'h4cca;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_count  = 0;
        model_wcount = 0;
        model_drops  = 0;
        model_state  = ST_IDLE;
        reset       <= 1'b1;
        dp_valid    <= 1'b0;
        dp_packet   <= '0;
        edge_valid  <= 1'b0;
        edge_packet <= '0;
        reg_wen     <= 1'b0;
        reg_ren     <= 1'b0;
        reg_addr    <= '0;
        reg_wdata   <= '0;
        out_pop     <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        check_reset_state();
        stream_in_order();
        apply_backpressure();
        drop_overflow();
        done_and_replay();
        clear_buffer();

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
source/packet_buffer_pkg.sv
source/packet_sram.sv
source/packet_fifo.sv
source/buffer_regs.sv
source/packet_store_ctrl.sv
source/packet_buffer_top.sv
bench/packet_buffer_tb.sv

// File: Makefile
# Verilator build and run for the packet buffer testbench

VERILATOR ?= verilator
TOP       ?= packet_buffer_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_TEXT := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILE_LIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
